// ==== common/exConsts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath and PC width, fixed by the 16-bit ISA
`define DATA_W 16

// Eight architectural registers
`define REG_ADDR_W 3

// Link register written by jal/jalr style instructions
`define LINK_REG 3'd7

// Software exception (siic) entry point
`define EXC_VECTOR 16'h0002

`endif

// ==== common/isaPkg.sv ====
package isaPkg;

    // ALU operation; group codes are resolved by funct in operand select
    typedef enum logic [4:0] {
        opAdd      = 5'd1,
        opSubRev   = 5'd2,
        opXor      = 5'd3,
        opAndn     = 5'd4,
        opRol      = 5'd5,
        opSll      = 5'd6,
        opRor      = 5'd7,
        opSrl      = 5'd8,
        opGrpArith = 5'd10,
        opGrpShift = 5'd11,
        opSeq      = 5'd12,
        opSlt      = 5'd13,
        opSle      = 5'd14,
        opSco      = 5'd15,
        opPassB    = 5'd16
    } aluOpE;

    // Conditional branch kind, tested against operand A
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brEqz  = 3'b100,
        brNez  = 3'b101,
        brLtz  = 3'b110,
        brGez  = 3'b111
    } branchCondE;

    // Destination field: Rd is 10:8, Rs is 7:5, Rt is 4:2
    typedef enum logic [1:0] {
        dstRs = 2'b00,
        dstRd = 2'b01,
        dstRt = 2'b10
    } regDstE;

endpackage

// ==== common/pipePkg.sv ====
package pipePkg;

    // Forwarding source for a register operand
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSelE;

    // Operand A source
    typedef enum logic [1:0] {
        srcAPc   = 2'b00,
        srcAZero = 2'b01,
        srcAReg  = 2'b10
    } srcASelE;

    // Operand B source
    typedef enum logic [1:0] {
        srcBZero = 2'b00,
        srcBReg  = 2'b01,
        srcBImm  = 2'b10
    } srcBSelE;

endpackage

// ==== common/exIfs.sv ====
`timescale 1ns/1ps
`include "exConsts.svh"

// Operands and control from operand select into the ALU
interface aluOperandIf import isaPkg::*; ();
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    aluOpE              op;
    logic               invA;
    logic               invB;
    logic               cin;

    modport src  (output a, b, op, invA, invB, cin);
    modport sink (input  a, b, op, invA, invB, cin);
endinterface

// ALU result plus zero/sign flags of operand A
interface aluFlagsIf ();
    logic [`DATA_W-1:0] result;
    logic               eq;
    logic               ne;
    logic               lt;
    logic               geq;

    modport src  (output result, eq, ne, lt, geq);
    modport sink (input  result, eq, ne, lt, geq);
endinterface

// ==== execute/operandSelect.sv ====
`timescale 1ns/1ps
`include "exConsts.svh"

module operandSelect
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic [`DATA_W-1:0]     reg1Data,
    input  logic [`DATA_W-1:0]     reg2Data,
    input  logic [`DATA_W-1:0]     imm,
    input  logic [`DATA_W-1:0]     pcAdd2,
    input  logic [`DATA_W-1:0]     memFwdData,
    input  logic [`DATA_W-1:0]     wbFwdData,
    input  fwdSelE                 fwdA,
    input  fwdSelE                 fwdB,
    input  srcASelE                srcA,
    input  srcBSelE                srcB,
    input  aluOpE                  aluOpIn,
    input  logic [1:0]             funct,
    input  logic [`DATA_W-1:0]     instr,
    input  regDstE                 regDst,
    input  logic                   linkWrite,
    output logic [`REG_ADDR_W-1:0] writeRegSel,
    aluOperandIf.src               opnd
);

    logic [`DATA_W-1:0] regA;
    logic [`DATA_W-1:0] regB;
    aluOpE              opRes;

    // Register value after the bypass network
    function automatic logic [`DATA_W-1:0] pickFwd(
        input fwdSelE             sel,
        input logic [`DATA_W-1:0] regVal,
        input logic [`DATA_W-1:0] memVal,
        input logic [`DATA_W-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign regA = pickFwd(fwdA, reg1Data, memFwdData, wbFwdData);
    assign regB = pickFwd(fwdB, reg2Data, memFwdData, wbFwdData);

    // Operand A: PC for link/PC-relative, zero for loads of immediates
    always_comb begin
        case (srcA)
            srcAPc:   opnd.a = pcAdd2;
            srcAZero: opnd.a = '0;
            default:  opnd.a = regA;
        endcase
    end

    always_comb begin
        case (srcB)
            srcBZero: opnd.b = '0;
            srcBImm:  opnd.b = imm;
            default:  opnd.b = regB;
        endcase
    end

    // Grouped R-type ops pick the real operation from funct
    always_comb begin
        case (aluOpIn)
            opGrpArith: opRes = (funct == 2'b00) ? opAdd    :
                                (funct == 2'b01) ? opSubRev :
                                (funct == 2'b10) ? opXor    : opAndn;
            opGrpShift: opRes = (funct == 2'b00) ? opRol :
                                (funct == 2'b01) ? opSll :
                                (funct == 2'b10) ? opRor : opSrl;
            default:    opRes = aluOpIn;
        endcase
    end

    assign opnd.op = opRes;

    // subRev computes B - A; andn and compares need inverted B
    assign opnd.invA = (opRes == opSubRev);
    assign opnd.invB = opRes inside {opAndn, opSeq, opSlt, opSle};
    // +1 completes the two's complement of the inverted side
    assign opnd.cin  = opnd.invA | opnd.invB;

    // Link writes go to r7, else the field chosen by decode
    always_comb begin
        if (linkWrite) begin
            writeRegSel = `LINK_REG;
        end else begin
            case (regDst)
                dstRd:   writeRegSel = instr[10:8];
                dstRt:   writeRegSel = instr[4:2];
                default: writeRegSel = instr[7:5];
            endcase
        end
    end

    // Only operations the ALU implements may leave here, never a group code
    knownOp: assert final ($isunknown(aluOpIn) ||
                           (opRes inside {opAdd, opSubRev, opXor, opAndn, opRol, opSll,
                                          opRor, opSrl, opSeq, opSlt, opSle, opSco, opPassB}))
        else $error("operandSelect: opcode %0d has no ALU operation", aluOpIn);

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/1ps
`include "exConsts.svh"

module alu
    import isaPkg::*;
(
    aluOperandIf.sink opnd,
    aluFlagsIf.src    flags
);

    localparam int W = `DATA_W;

    logic [W-1:0]   aIn;
    logic [W-1:0]   bIn;
    logic [W:0]     sum;
    logic [3:0]     shAmt;
    logic [2*W-1:0] rolDbl;
    logic [2*W-1:0] rorDbl;
    logic           ovf;
    logic           lessThan;
    logic           equal;

    // Conditional inversion feeds the single adder
    assign aIn = opnd.invA ? ~opnd.a : opnd.a;
    assign bIn = opnd.invB ? ~opnd.b : opnd.b;

    // One extra bit keeps the carry out for sco
    assign sum = {1'b0, aIn} + {1'b0, bIn} + {{W{1'b0}}, opnd.cin};

    // Signed overflow of A - B when comparing
    assign ovf      = (aIn[W-1] == bIn[W-1]) && (sum[W-1] != aIn[W-1]);
    assign lessThan = sum[W-1] ^ ovf;
    assign equal    = (sum[W-1:0] == '0);

    // Only the low nibble of B counts for shifts
    assign shAmt  = opnd.b[3:0];
    // Rotates via a doubled copy of A
    assign rolDbl = {opnd.a, opnd.a} << shAmt;
    assign rorDbl = {opnd.a, opnd.a} >> shAmt;

    always_comb begin
        case (opnd.op)
            opAdd,
            opSubRev: flags.result = sum[W-1:0];
            opXor:    flags.result = aIn ^ bIn;
            opAndn:   flags.result = aIn & bIn;
            opRol:    flags.result = rolDbl[2*W-1:W];
            opSll:    flags.result = opnd.a << shAmt;
            opRor:    flags.result = rorDbl[W-1:0];
            opSrl:    flags.result = opnd.a >> shAmt;
            opSeq:    flags.result = {{(W-1){1'b0}}, equal};
            opSlt:    flags.result = {{(W-1){1'b0}}, lessThan};
            opSle:    flags.result = {{(W-1){1'b0}}, lessThan | equal};
            // Carry out of A + B, no inversion on this op
            opSco:    flags.result = {{(W-1){1'b0}}, sum[W]};
            opPassB:  flags.result = opnd.b;
            default:  flags.result = '0;
        endcase
    end

    // Branch flags look at raw operand A against zero
    assign flags.eq  = (opnd.a == '0);
    assign flags.ne  = |opnd.a;
    assign flags.lt  = opnd.a[W-1];
    assign flags.geq = ~opnd.a[W-1];

    // Adder-based compare relies on invB and cin from operand select
    cmpConsistent: assert final ($isunknown({opnd.a, opnd.b, opnd.op}) ||
                                 !(opnd.op inside {opSeq, opSlt, opSle}) ||
                                 ((lessThan == ($signed(opnd.a) < $signed(opnd.b))) &&
                                  (equal == (opnd.a == opnd.b))))
        else $error("alu: compare disagrees for A=%h B=%h", opnd.a, opnd.b);

endmodule

// ==== execute/pcResolve.sv ====
`timescale 1ns/1ps
`include "exConsts.svh"

module pcResolve
    import isaPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    aluFlagsIf.sink            flags,
    input  branchCondE         branchCond,
    input  logic               jump,
    input  logic               siic,
    input  logic               rti,
    input  logic               haltIn,
    input  logic [`DATA_W-1:0] pcAdd2,
    input  logic [`DATA_W-1:0] imm,
    output logic [`DATA_W-1:0] nextPc,
    output logic               pcChange,
    output logic               haltOut
);

    logic               takeBranch;
    logic [`DATA_W-1:0] brTarget;
    logic [`DATA_W-1:0] excPc;

    always_comb begin
        case (branchCond)
            brEqz:   takeBranch = flags.eq;
            brNez:   takeBranch = flags.ne;
            brLtz:   takeBranch = flags.lt;
            brGez:   takeBranch = flags.geq;
            default: takeBranch = 1'b0;
        endcase
    end

    // Word offset, so immediate is doubled
    assign brTarget = pcAdd2 + (imm << 1);

    // EPC holds the return address of the last siic
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            excPc <= '0;
        end else if (siic) begin
            excPc <= pcAdd2;
        end
    end

    // Branch wins, then jump, siic, rti
    always_comb begin
        if (takeBranch)  nextPc = brTarget;
        else if (jump)   nextPc = flags.result;
        else if (siic)   nextPc = `EXC_VECTOR;
        else if (rti)    nextPc = excPc;
        else             nextPc = pcAdd2;
    end

    assign pcChange = takeBranch | jump | siic | rti;
    // A halt fetched behind a redirect is on the wrong path
    assign haltOut  = haltIn & ~pcChange;

    // Decode never issues siic and rti in the same slot
    siicRtiExclusive: assert property (@(posedge clk) disable iff (!rstN) !(siic && rti))
        else $error("pcResolve: siic and rti together");

endmodule

// ==== hw/executeStage.sv ====
`timescale 1ns/1ps
`include "exConsts.svh"

module executeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`DATA_W-1:0]     reg1Data,
    input  logic [`DATA_W-1:0]     reg2Data,
    input  logic [`DATA_W-1:0]     imm,
    input  logic [`DATA_W-1:0]     pcAdd2,
    input  logic [`DATA_W-1:0]     memFwdData,
    input  logic [`DATA_W-1:0]     wbFwdData,
    input  fwdSelE                 fwdA,
    input  fwdSelE                 fwdB,
    input  srcASelE                srcA,
    input  srcBSelE                srcB,
    input  aluOpE                  aluOpIn,
    input  logic [1:0]             funct,
    input  logic [`DATA_W-1:0]     instr,
    input  regDstE                 regDst,
    input  logic                   linkWrite,
    input  branchCondE             branchCond,
    input  logic                   jump,
    input  logic                   siic,
    input  logic                   rti,
    input  logic                   haltIn,
    output logic [`DATA_W-1:0]     aluOut,
    output logic [`REG_ADDR_W-1:0] writeRegSel,
    output logic [`DATA_W-1:0]     nextPc,
    output logic                   pcChange,
    output logic                   haltOut
);

    aluOperandIf operandBus ();
    aluFlagsIf   flagsBus ();

    operandSelect operandSelect_inst (
        .reg1Data    (reg1Data),
        .reg2Data    (reg2Data),
        .imm         (imm),
        .pcAdd2      (pcAdd2),
        .memFwdData  (memFwdData),
        .wbFwdData   (wbFwdData),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .srcA        (srcA),
        .srcB        (srcB),
        .aluOpIn     (aluOpIn),
        .funct       (funct),
        .instr       (instr),
        .regDst      (regDst),
        .linkWrite   (linkWrite),
        .writeRegSel (writeRegSel),
        .opnd        (operandBus.src)
    );

    alu alu_inst (
        .opnd  (operandBus.sink),
        .flags (flagsBus.src)
    );

    pcResolve pcResolve_inst (
        .clk        (clk),
        .rstN       (rstN),
        .flags      (flagsBus.sink),
        .branchCond (branchCond),
        .jump       (jump),
        .siic       (siic),
        .rti        (rti),
        .haltIn     (haltIn),
        .pcAdd2     (pcAdd2),
        .imm        (imm),
        .nextPc     (nextPc),
        .pcChange   (pcChange),
        .haltOut    (haltOut)
    );

    // Result heads on to the execute/memory register
    assign aluOut = flagsBus.result;

endmodule

// ==== test/executeStageTb.sv ====
`timescale 1ns/1ps
`include "exConsts.svh"

module executeStageTb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int W            = `DATA_W;
    localparam int CLK_PERIOD   = 8;
    localparam int ARITH_VECS   = 32;
    localparam int FWD_VECS     = 24;
    localparam int OPS_VECS     = 54;
    localparam int BRANCH_VECS  = 30;
    localparam int EXC_VECS     = 9;
    localparam int DST_VECS     = 32;
    localparam int TOTAL_VECS   = ARITH_VECS + FWD_VECS + OPS_VECS + BRANCH_VECS
                                + EXC_VECS + DST_VECS;
    // Covers both resets and the idle cycle at the end of each test
    localparam int SLACK_CYCLES = 40;

    logic                   clk;
    logic                   rstN;
    logic [W-1:0]           reg1Data;
    logic [W-1:0]           reg2Data;
    logic [W-1:0]           imm;
    logic [W-1:0]           pcAdd2;
    logic [W-1:0]           memFwdData;
    logic [W-1:0]           wbFwdData;
    fwdSelE                 fwdA;
    fwdSelE                 fwdB;
    srcASelE                srcA;
    srcBSelE                srcB;
    aluOpE                  aluOpIn;
    logic [1:0]             funct;
    logic [W-1:0]           instr;
    regDstE                 regDst;
    logic                   linkWrite;
    branchCondE             branchCond;
    logic                   jump;
    logic                   siic;
    logic                   rti;
    logic                   haltIn;
    logic [W-1:0]           aluOut;
    logic [`REG_ADDR_W-1:0] writeRegSel;
    logic [W-1:0]           nextPc;
    logic                   pcChange;
    logic                   haltOut;

    // Reference model outputs
    logic [W-1:0]           expA;
    logic [W-1:0]           expB;
    aluOpE                  expOp;
    logic [W-1:0]           expAlu;
    logic                   expTaken;
    logic                   expPcChange;
    logic [W-1:0]           expNextPc;
    logic                   expHalt;
    logic [`REG_ADDR_W-1:0] expWriteReg;
    logic [W-1:0]           excPcModel;

    int errorCount;
    int testCount;

    executeStage executeStage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [W-1:0] randWord();
        logic [31:0] r;
        r = $urandom;
        return r[W-1:0];
    endfunction

    // Zero, sign-bit and all-ones corners mixed with random values
    function automatic logic [W-1:0] pickOperand();
        int unsigned sel;
        sel = $urandom % 8;
        case (sel)
            0:       return '0;
            1:       return {1'b1, {(W-1){1'b0}}};
            2:       return '1;
            3:       return {1'b0, {(W-1){1'b1}}};
            default: return randWord();
        endcase
    endfunction

    // 0 gives zero, 1 negative, 2 positive
    function automatic logic [W-1:0] operandOfSign(input int kind);
        case (kind)
            0:       return '0;
            1:       return randWord() | {1'b1, {(W-1){1'b0}}};
            default: return (randWord() & {1'b0, {(W-1){1'b1}}}) | 1;
        endcase
    endfunction

    function automatic fwdSelE fwdFromIndex(input int i);
        case (i)
            1:       return fwdWb;
            2:       return fwdMem;
            default: return fwdNone;
        endcase
    endfunction

    function automatic branchCondE condFromIndex(input int i);
        case (i)
            0:       return brEqz;
            1:       return brNez;
            2:       return brLtz;
            default: return brGez;
        endcase
    endfunction

    function automatic logic [W-1:0] forwardValue(input fwdSelE sel, input logic [W-1:0] regVal,
                                                  input logic [W-1:0] mem, input logic [W-1:0] wb);
        if (sel == fwdMem) return mem;
        if (sel == fwdWb) return wb;
        return regVal;
    endfunction

    function automatic aluOpE resolveGroupOp(input aluOpE op, input logic [1:0] f);
        aluOpE arith [4];
        aluOpE shift [4];
        arith = '{opAdd, opSubRev, opXor, opAndn};
        shift = '{opRol, opSll, opRor, opSrl};
        if (op == opGrpArith) return arith[f];
        if (op == opGrpShift) return shift[f];
        return op;
    endfunction

    function automatic logic [W-1:0] computeAlu(input aluOpE op, input logic [W-1:0] a,
                                                input logic [W-1:0] b);
        logic [3:0] sh;
        logic [W:0] wide;
        sh   = b[3:0];
        wide = {1'b0, a} + {1'b0, b};
        case (op)
            opAdd:    return a + b;
            // Reverse subtract, B minus A
            opSubRev: return b - a;
            opXor:    return a ^ b;
            opAndn:   return a & ~b;
            opRol:    return (a << sh) | (a >> (W - sh));
            opSll:    return a << sh;
            opRor:    return (a >> sh) | (a << (W - sh));
            opSrl:    return a >> sh;
            opSeq:    return (a == b) ? 1 : 0;
            opSlt:    return ($signed(a) < $signed(b)) ? 1 : 0;
            opSle:    return ($signed(a) <= $signed(b)) ? 1 : 0;
            opSco:    return {{(W-1){1'b0}}, wide[W]};
            opPassB:  return b;
            default:  return '0;
        endcase
    endfunction

    // Conditions look at operand A against zero
    function automatic logic branchTaken(input branchCondE cond, input logic [W-1:0] a);
        case (cond)
            brEqz:   return a == '0;
            brNez:   return a != '0;
            brLtz:   return a[W-1];
            brGez:   return !a[W-1];
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [W-1:0] selectNextPc(input logic taken, input logic jmp,
                                                  input logic exc, input logic ret,
                                                  input logic [W-1:0] pc,
                                                  input logic [W-1:0] offs,
                                                  input logic [W-1:0] aluRes,
                                                  input logic [W-1:0] epc);
        if (taken) return pc + {offs[W-2:0], 1'b0};
        if (jmp) return aluRes;
        if (exc) return `EXC_VECTOR;
        if (ret) return epc;
        return pc;
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] destinationReg(input logic link,
                                                              input regDstE dst,
                                                              input logic [W-1:0] ins);
        if (link) return 3'd7;
        case (dst)
            dstRd:   return ins[10:8];
            dstRs:   return ins[7:5];
            default: return ins[4:2];
        endcase
    endfunction

    assign expA        = (srcA == srcAPc)   ? pcAdd2 :
                         (srcA == srcAZero) ? '0 :
                         forwardValue(fwdA, reg1Data, memFwdData, wbFwdData);
    assign expB        = (srcB == srcBZero) ? '0 :
                         (srcB == srcBImm)  ? imm :
                         forwardValue(fwdB, reg2Data, memFwdData, wbFwdData);
    assign expOp       = resolveGroupOp(aluOpIn, funct);
    assign expAlu      = computeAlu(expOp, expA, expB);
    assign expTaken    = branchTaken(branchCond, expA);
    assign expPcChange = expTaken | jump | siic | rti;
    assign expNextPc   = selectNextPc(expTaken, jump, siic, rti, pcAdd2, imm, expAlu,
                                      excPcModel);
    assign expHalt     = haltIn & ~expPcChange;
    assign expWriteReg = destinationReg(linkWrite, regDst, instr);

    // Exception PC saved by every siic
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            excPcModel <= '0;
        end else if (siic) begin
            excPcModel <= pcAdd2;
        end
    end

    task automatic reportMismatch(input string name, input logic [W-1:0] got,
                                  input logic [W-1:0] expected);
        $display("ERROR %t: %s is %h, expected %h", $time, name, got, expected);
        errorCount++;
    endtask

    aluOutChk: assert property (@(posedge clk) disable iff (!rstN) aluOut == expAlu)
        else reportMismatch("aluOut", $sampled(aluOut), $sampled(expAlu));
    writeRegChk: assert property (@(posedge clk) disable iff (!rstN) writeRegSel == expWriteReg)
        else reportMismatch("writeRegSel", W'($sampled(writeRegSel)), W'($sampled(expWriteReg)));
    nextPcChk: assert property (@(posedge clk) disable iff (!rstN) nextPc == expNextPc)
        else reportMismatch("nextPc", $sampled(nextPc), $sampled(expNextPc));
    pcChangeChk: assert property (@(posedge clk) disable iff (!rstN) pcChange == expPcChange)
        else reportMismatch("pcChange", W'($sampled(pcChange)), W'($sampled(expPcChange)));
    haltOutChk: assert property (@(posedge clk) disable iff (!rstN) haltOut == expHalt)
        else reportMismatch("haltOut", W'($sampled(haltOut)), W'($sampled(expHalt)));

    task automatic idleControls();
        fwdA       = fwdNone;
        fwdB       = fwdNone;
        srcA       = srcAReg;
        srcB       = srcBReg;
        aluOpIn    = opAdd;
        funct      = 2'b00;
        regDst     = dstRd;
        linkWrite  = 1'b0;
        branchCond = brNone;
        jump       = 1'b0;
        siic       = 1'b0;
        rti        = 1'b0;
        haltIn     = 1'b0;
    endtask

    task automatic randomData();
        reg1Data   = randWord();
        reg2Data   = randWord();
        imm        = randWord();
        pcAdd2     = randWord();
        memFwdData = randWord();
        wbFwdData  = randWord();
        instr      = randWord();
    endtask

    // New vector on the falling edge, checked on the next rising edge
    task automatic nextVector();
        @(negedge clk);
        idleControls();
        randomData();
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        @(negedge clk);
        testCount++;
        if (errorCount == errsBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errorCount - errsBefore);
        end
    endtask

    task automatic arithTest();
        int errsBefore;
        errsBefore = errorCount;
        for (int i = 0; i < ARITH_VECS; i++) begin
            nextVector();
            aluOpIn = opGrpArith;
            funct   = i[1:0];
            srcB    = i[2] ? srcBImm : srcBReg;
        end
        finishTest("arith group", errsBefore);
    endtask

    task automatic forwardTest();
        int errsBefore;
        errsBefore = errorCount;
        for (int pass = 0; pass < 2; pass++) begin
            // subRev tells A and B apart
            for (int k = 0; k < 9; k++) begin
                nextVector();
                fwdA    = fwdFromIndex(k / 3);
                fwdB    = fwdFromIndex(k % 3);
                aluOpIn = opGrpArith;
                funct   = 2'b01;
            end
            for (int k = 0; k < 3; k++) begin
                nextVector();
                fwdA    = fwdFromIndex(k);
                fwdB    = fwdFromIndex(2 - k);
                aluOpIn = opGrpArith;
                funct   = 2'b01;
                srcA    = (k == 0) ? srcAPc : (k == 1) ? srcAZero : srcAReg;
                srcB    = (k == 2) ? srcBZero : srcBReg;
            end
        end
        finishTest("forwarding", errsBefore);
    endtask

    task automatic opsTest();
        int errsBefore;
        int kind;
        errsBefore = errorCount;
        for (int i = 0; i < OPS_VECS; i++) begin
            nextVector();
            kind     = i % 9;
            reg1Data = pickOperand();
            reg2Data = pickOperand();
            imm      = pickOperand();
            // Equal operands so seq and sle also return one
            if ($urandom % 4 == 0) begin
                reg2Data = reg1Data;
            end
            case (kind)
                0, 1, 2, 3: begin
                    aluOpIn = opGrpShift;
                    funct   = kind[1:0];
                end
                4:       aluOpIn = opSeq;
                5:       aluOpIn = opSlt;
                6:       aluOpIn = opSle;
                7:       aluOpIn = opSco;
                default: aluOpIn = opPassB;
            endcase
            srcB = (kind == 8) ? srcBImm : srcBReg;
        end
        finishTest("shift, compare, sco, passB", errsBefore);
    endtask

    task automatic branchTest();
        int errsBefore;
        errsBefore = errorCount;
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < 12; k++) begin
                nextVector();
                reg1Data   = operandOfSign(k % 3);
                branchCond = condFromIndex(k / 3);
                aluOpIn    = opPassB;
                haltIn     = 1'b1;
            end
            // Jump goes to A plus imm
            for (int k = 0; k < 2; k++) begin
                nextVector();
                jump   = 1'b1;
                srcB   = srcBImm;
                haltIn = 1'b1;
            end
            // Halt passes when nothing redirects
            nextVector();
            haltIn = 1'b1;
        end
        finishTest("branch and jump", errsBefore);
    endtask

    task automatic excTest();
        int errsBefore;
        errsBefore = errorCount;
        for (int k = 0; k < 3; k++) begin
            nextVector();
            siic   = 1'b1;
            haltIn = 1'b1;
            nextVector();
            rti = 1'b1;
        end
        // Save a return address that the reset has to clear
        nextVector();
        siic = 1'b1;
        nextVector();
        applyReset();
        // EPC back at its reset value
        nextVector();
        rti = 1'b1;
        finishTest("siic and rti", errsBefore);
    endtask

    task automatic dstTest();
        int errsBefore;
        errsBefore = errorCount;
        for (int i = 0; i < DST_VECS; i++) begin
            nextVector();
            case (i % 4)
                0:       linkWrite = 1'b1;
                1:       regDst = dstRd;
                2:       regDst = dstRs;
                default: regDst = dstRt;
            endcase
        end
        finishTest("destination select", errsBefore);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(85));
        errorCount = 0;
        testCount  = 0;
        idleControls();
        randomData();
        applyReset();
        arithTest();
        forwardTest();
        opsTest();
        branchTest();
        excTest();
        dstTest();
        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Limit from the total vector count plus slack
    initial begin
        #((TOTAL_VECS + SLACK_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired after %0d ns, the tests did not complete",
                 (TOTAL_VECS + SLACK_CYCLES) * CLK_PERIOD);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
common/exIfs.sv
execute/operandSelect.sv
execute/alu.sv
execute/pcResolve.sv
hw/executeStage.sv
test/executeStageTb.sv

// ==== Bender.yml ====
package:
  name: executeStage

export_include_dirs:
  - common

sources:
  - common/isaPkg.sv
  - common/pipePkg.sv
  - common/exIfs.sv
  - execute/operandSelect.sv
  - execute/alu.sv
  - execute/pcResolve.sv
  - hw/executeStage.sv
  - target: test
    files:
      - test/executeStageTb.sv
